// ==== src/crc_pkg.sv ====
/* Constants shared by the CRC users of the link:
   register width, word width fed per enable, and the start value. */
package crc_pkg;

    // CRC-16 with polynomial x^16 + x^12 + x^5 + 1, MSB first.
    localparam int CRC_WIDTH = 16;  // one link word.

    localparam int DATA_WIDTH = 16;  // bits folded per enable.

    // no reflection and no final xor, so the register goes out as is.
    localparam logic [CRC_WIDTH-1:0] CRC_INIT = '1;  // all ones.

endpackage

// ==== src/link_pkg.sv ====
/* Frame format constants of the link, the header word union
   and the state codes of the transmit sequencer. */
package link_pkg;

    localparam int WORD_WIDTH = crc_pkg::DATA_WIDTH;  // link word.
    localparam int TYPE_WIDTH = 8;
    localparam int LEN_WIDTH  = 8;  // payload lengths 0 to 255.
    localparam int CNT_WIDTH  = 16;  // statistics counters.

    // transmit sequencer.
    localparam int                     TX_ST_WIDTH = 2;
    localparam logic [TX_ST_WIDTH-1:0] TX_IDLE     = 2'd0;
    localparam logic [TX_ST_WIDTH-1:0] TX_PAYLOAD  = 2'd1;
    localparam logic [TX_ST_WIDTH-1:0] TX_CRC      = 2'd2;

    // Header word, built through its fields and carried raw on the link.
    typedef union packed {
        struct packed {
            logic [TYPE_WIDTH-1:0] frame_type;  // upper byte.
            logic [LEN_WIDTH-1:0]  length;  // payload words.
        } fields;
        logic [WORD_WIDTH-1:0] raw;
    } hdr_word_u;

endpackage

// ==== src/crc.sv ====
/* CRC register folding one data word per enable, MSB first, one step per bit.
   Polynomials for widths 8, 16, 32 and 64; synchronous clear restarts a frame. */
`timescale 1ns/1ps

module crc #(
    parameter int                   DATA_WIDTH = 16,
    parameter int                   CRC_WIDTH  = 16,
    parameter logic [CRC_WIDTH-1:0] INIT_VAL   = '1
) (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  clr_i,
    input  logic                  en_i,
    input  logic [DATA_WIDTH-1:0] data_i,
    output logic [ CRC_WIDTH-1:0] crc_o
);

    // 8: x^8+x^2+x+1, 16: x^16+x^12+x^5+1, 32: MPEG-2, 64: x^64+x^4+x^3+x+1
    localparam logic [63:0] POLY_SEL = (CRC_WIDTH == 8)  ? 64'h07 :
                                       (CRC_WIDTH == 16) ? 64'h1021 :
                                       (CRC_WIDTH == 32) ? 64'h04c1_1db7 :
                                                           64'h1b;
    localparam logic [CRC_WIDTH-1:0] POLY = POLY_SEL[CRC_WIDTH-1:0];

    logic [CRC_WIDTH-1:0] base;  // value the next word folds into.

    if ((CRC_WIDTH != 8) && (CRC_WIDTH != 16) &&
        (CRC_WIDTH != 32) && (CRC_WIDTH != 64)) begin : g_width_check
        $fatal(1, "crc: unsupported CRC_WIDTH %0d", CRC_WIDTH);
    end

    // one shift of the serial register.
    function automatic logic [CRC_WIDTH-1:0] crc_step(input logic [CRC_WIDTH-1:0] crc,
                                                      input logic                 bit_in);
        logic fb;
        fb = crc[CRC_WIDTH-1] ^ bit_in;  // feedback tap.
        return {crc[CRC_WIDTH-2:0], 1'b0} ^ (fb ? POLY : '0);
    endfunction

    // whole word, highest bit first.
    function automatic logic [CRC_WIDTH-1:0] crc_word(input logic [CRC_WIDTH-1:0]  crc,
                                                      input logic [DATA_WIDTH-1:0] data);
        logic [CRC_WIDTH-1:0] acc;
        acc = crc;
        for (int i = DATA_WIDTH - 1; i >= 0; i--) begin
            acc = crc_step(acc, data[i]);
        end
        return acc;
    endfunction

    assign base = clr_i ? INIT_VAL : crc_o;  // clear and fold in one edge.

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            crc_o <= INIT_VAL;
        end else if (en_i) begin
            crc_o <= crc_word(base, data_i);
        end else if (clr_i) begin
            crc_o <= INIT_VAL;  // restart, no data this cycle.
        end
    end

endmodule

// ==== src/tx_framer.sv ====
/* Transmit framer: sends the header word, then the payload strobes,
   then the CRC over header and payload, with sof and eof flags. */
`timescale 1ns/1ps

module tx_framer (
    input  logic                            clk_i,
    input  logic                            rstn_i,
    input  logic                            tx_start_i,
    input  logic [link_pkg::TYPE_WIDTH-1:0] tx_type_i,
    input  logic [ link_pkg::LEN_WIDTH-1:0] tx_len_i,
    input  logic                            tx_data_vld_i,
    input  logic [link_pkg::WORD_WIDTH-1:0] tx_data_i,
    output logic [link_pkg::WORD_WIDTH-1:0] link_o,
    output logic                            link_vld_o,
    output logic                            link_sof_o,
    output logic                            link_eof_o,
    output logic                            tx_busy_o
);

    import crc_pkg::*;
    import link_pkg::*;

    logic [TX_ST_WIDTH-1:0] state_q;
    logic [LEN_WIDTH-1:0]   remain_q;  // payload words still due.
    hdr_word_u              hdr;
    logic                   start_ok;
    logic                   data_ok;
    logic [WORD_WIDTH-1:0]  crc_data;
    logic [CRC_WIDTH-1:0]   crc_val;

    always_comb begin
        hdr.fields.frame_type = tx_type_i;
        hdr.fields.length     = tx_len_i;
    end

    assign start_ok = (state_q == TX_IDLE) && tx_start_i;  // start while busy is dropped.
    assign data_ok  = (state_q == TX_PAYLOAD) && tx_data_vld_i;
    assign crc_data = start_ok ? hdr.raw : tx_data_i;

    crc #(
        .DATA_WIDTH(DATA_WIDTH),
        .CRC_WIDTH (CRC_WIDTH),
        .INIT_VAL  (CRC_INIT)
    ) u_crc (
        .clk_i (clk_i),
        .rstn_i(rstn_i),
        .clr_i (start_ok),  // new frame starts from all ones.
        .en_i  (start_ok || data_ok),
        .data_i(crc_data),
        .crc_o (crc_val)
    );

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q    <= TX_IDLE;
            remain_q   <= '0;
            link_vld_o <= 1'b0;
            link_sof_o <= 1'b0;
            link_eof_o <= 1'b0;
            tx_busy_o  <= 1'b0;
        end else begin
            link_vld_o <= 1'b0;
            link_sof_o <= 1'b0;
            link_eof_o <= 1'b0;
            case (state_q)
                TX_IDLE: begin
                    if (tx_start_i) begin
                        link_vld_o <= 1'b1;
                        link_sof_o <= 1'b1;
                        tx_busy_o  <= 1'b1;
                        remain_q   <= tx_len_i;
                        state_q    <= (tx_len_i == '0) ? TX_CRC : TX_PAYLOAD;
                    end
                end
                TX_PAYLOAD: begin
                    if (tx_data_vld_i) begin
                        link_vld_o <= 1'b1;
                        remain_q   <= remain_q - LEN_WIDTH'(1);
                        if (remain_q == LEN_WIDTH'(1)) begin
                            state_q <= TX_CRC;  // last payload word.
                        end
                    end
                end
                TX_CRC: begin
                    link_vld_o <= 1'b1;
                    link_eof_o <= 1'b1;
                    tx_busy_o  <= 1'b0;
                    state_q    <= TX_IDLE;
                end
                default: state_q <= TX_IDLE;
            endcase
        end
    end

    // word mux: header or payload, else the finished crc.
    always_ff @(posedge clk_i) begin
        if (start_ok || data_ok) begin
            link_o <= crc_data;
        end else if (state_q == TX_CRC) begin
            link_o <= crc_val;
        end
    end

endmodule

// ==== src/rx_checker.sv ====
/* Receive checker: delimits frames by sof and length, forwards payload,
   recomputes the CRC and gives one verdict per frame. */
`timescale 1ns/1ps

module rx_checker (
    input  logic                            clk_i,
    input  logic                            rstn_i,
    input  logic [link_pkg::WORD_WIDTH-1:0] link_i,
    input  logic                            link_vld_i,
    input  logic                            link_sof_i,
    input  logic                            link_eof_i,
    output logic [link_pkg::WORD_WIDTH-1:0] rx_data_o,
    output logic                            rx_data_vld_o,
    output logic                            rx_done_o,
    output logic                            rx_crc_ok_o,
    output logic                            rx_len_err_o,
    output logic [link_pkg::TYPE_WIDTH-1:0] rx_type_o
);

    import crc_pkg::*;
    import link_pkg::*;

    logic                 in_frame_q;
    logic [LEN_WIDTH-1:0] len_q;  // length from the header.
    logic [LEN_WIDTH-1:0] cnt_q;  // payload words seen so far.
    hdr_word_u            hdr;
    logic                 hdr_ok;
    logic                 body_ok;
    logic                 crc_due;
    logic                 frame_end;
    logic [CRC_WIDTH-1:0] crc_val;

    assign hdr.raw   = link_i;
    assign hdr_ok    = link_vld_i && link_sof_i;  // also abandons a running frame.
    assign body_ok   = link_vld_i && !link_sof_i && in_frame_q;
    assign crc_due   = (cnt_q == len_q);
    assign frame_end = body_ok && (crc_due || link_eof_i);  // early eof ends it too.

    crc #(
        .DATA_WIDTH(DATA_WIDTH),
        .CRC_WIDTH (CRC_WIDTH),
        .INIT_VAL  (CRC_INIT)
    ) u_crc (
        .clk_i (clk_i),
        .rstn_i(rstn_i),
        .clr_i (hdr_ok),
        .en_i  (hdr_ok || (body_ok && !frame_end)),
        .data_i(link_i),
        .crc_o (crc_val)
    );

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            in_frame_q    <= 1'b0;
            cnt_q         <= '0;
            rx_data_vld_o <= 1'b0;
            rx_done_o     <= 1'b0;
        end else begin
            rx_data_vld_o <= 1'b0;
            rx_done_o     <= 1'b0;
            if (hdr_ok) begin
                in_frame_q <= !link_eof_i;
                cnt_q      <= '0;
                rx_done_o  <= link_eof_i;  // eof on the header itself.
            end else if (frame_end) begin
                in_frame_q <= 1'b0;
                rx_done_o  <= 1'b1;
            end else if (body_ok) begin
                rx_data_vld_o <= 1'b1;
                cnt_q         <= cnt_q + LEN_WIDTH'(1);
            end
        end
    end

    // payload and verdict values, qualified by the strobes above.
    always_ff @(posedge clk_i) begin
        if (hdr_ok) begin
            len_q        <= hdr.fields.length;
            rx_type_o    <= hdr.fields.frame_type;
            rx_crc_ok_o  <= 1'b0;
            rx_len_err_o <= 1'b1;
        end
        if (body_ok) begin
            rx_data_o <= link_i;
        end
        if (frame_end) begin
            rx_crc_ok_o  <= (link_i == crc_val);
            rx_len_err_o <= !(crc_due && link_eof_i);  // eof must sit on the crc word.
        end
    end

endmodule

// ==== src/link_stats.sv ====
/* Saturating counters of good and bad received frames. */
`timescale 1ns/1ps

module link_stats (
    input  logic                           clk_i,
    input  logic                           rstn_i,
    input  logic                           done_i,
    input  logic                           crc_ok_i,
    input  logic                           len_err_i,
    output logic [link_pkg::CNT_WIDTH-1:0] good_cnt_o,
    output logic [link_pkg::CNT_WIDTH-1:0] bad_cnt_o
);

    import link_pkg::*;

    logic good;

    assign good = crc_ok_i && !len_err_i;  // both checks must pass.

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            good_cnt_o <= '0;
            bad_cnt_o  <= '0;
        end else if (done_i) begin
            if (good) begin
                if (good_cnt_o != '1) begin
                    good_cnt_o <= good_cnt_o + CNT_WIDTH'(1);
                end
            end else if (bad_cnt_o != '1) begin
                bad_cnt_o <= bad_cnt_o + CNT_WIDTH'(1);  // held at max.
            end
        end
    end

endmodule

// ==== src/crc_link_top.sv ====
/* Top level of the CRC-16 framing link: framer on the transmit side,
   checker and frame statistics on the receive side. */
`timescale 1ns/1ps

module crc_link_top (
    input  logic                            clk_i,
    input  logic                            rstn_i,
    // transmit side.
    input  logic                            tx_start_i,
    input  logic [link_pkg::TYPE_WIDTH-1:0] tx_type_i,
    input  logic [ link_pkg::LEN_WIDTH-1:0] tx_len_i,
    input  logic                            tx_data_vld_i,
    input  logic [link_pkg::WORD_WIDTH-1:0] tx_data_i,
    output logic                            tx_busy_o,
    output logic [link_pkg::WORD_WIDTH-1:0] link_o,
    output logic                            link_vld_o,
    output logic                            link_sof_o,
    output logic                            link_eof_o,
    // receive side.
    input  logic [link_pkg::WORD_WIDTH-1:0] link_i,
    input  logic                            link_vld_i,
    input  logic                            link_sof_i,
    input  logic                            link_eof_i,
    output logic [link_pkg::WORD_WIDTH-1:0] rx_data_o,
    output logic                            rx_data_vld_o,
    output logic                            rx_done_o,
    output logic                            rx_crc_ok_o,
    output logic                            rx_len_err_o,
    output logic [link_pkg::TYPE_WIDTH-1:0] rx_type_o,
    output logic [ link_pkg::CNT_WIDTH-1:0] good_cnt_o,
    output logic [ link_pkg::CNT_WIDTH-1:0] bad_cnt_o
);

    tx_framer u_tx_framer (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .tx_start_i   (tx_start_i),
        .tx_type_i    (tx_type_i),
        .tx_len_i     (tx_len_i),
        .tx_data_vld_i(tx_data_vld_i),
        .tx_data_i    (tx_data_i),
        .link_o       (link_o),
        .link_vld_o   (link_vld_o),
        .link_sof_o   (link_sof_o),
        .link_eof_o   (link_eof_o),
        .tx_busy_o    (tx_busy_o)
    );

    rx_checker u_rx_checker (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .link_i       (link_i),
        .link_vld_i   (link_vld_i),
        .link_sof_i   (link_sof_i),
        .link_eof_i   (link_eof_i),
        .rx_data_o    (rx_data_o),
        .rx_data_vld_o(rx_data_vld_o),
        .rx_done_o    (rx_done_o),
        .rx_crc_ok_o  (rx_crc_ok_o),
        .rx_len_err_o (rx_len_err_o),
        .rx_type_o    (rx_type_o)
    );

    // verdict nets are shared with the receive outputs.
    link_stats u_link_stats (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .done_i    (rx_done_o),
        .crc_ok_i  (rx_crc_ok_o),
        .len_err_i (rx_len_err_o),
        .good_cnt_o(good_cnt_o),
        .bad_cnt_o (bad_cnt_o)
    );

endmodule

// ==== dv/tb_crc_link_top.sv ====
/* Testbench of the CRC-16 framing link with clock and reset, loopback with corruption
   and truncation, reference CRC, directed tests, watchdog and summary. */
`timescale 1ns/1ps

module tb_crc_link_top;

    import link_pkg::*;

    localparam int          RESET_CYCLES   = 4;
    localparam int          MAX_RAND_LEN   = 32;  // longest random payload.
    localparam int          MAX_GAP        = 2;  // idle cycles between strobes.
    localparam int          FRAME_COUNT    = 24;  // frames over all tests.
    localparam int          FRAME_CYCLES   = MAX_RAND_LEN * (MAX_GAP + 1) + 12;
    localparam int          TIMEOUT_CYCLES = 2 * (RESET_CYCLES + FRAME_COUNT * FRAME_CYCLES);
    localparam logic [15:0] REF_POLY       = 16'h1021;  // x^16 + x^12 + x^5 + 1.
    localparam logic [15:0] REF_INIT       = 16'hffff;

    logic                  clk_i = 1'b0;
    logic                  rstn_i;
    logic                  tx_start_i, tx_data_vld_i, tx_busy_o;
    logic [TYPE_WIDTH-1:0] tx_type_i;
    logic [LEN_WIDTH-1:0]  tx_len_i;
    logic [WORD_WIDTH-1:0] tx_data_i, link_o, link_i, rx_data_o;
    logic                  link_vld_o, link_sof_o, link_eof_o;
    logic                  link_vld_i, link_sof_i, link_eof_i;
    logic                  rx_data_vld_o, rx_done_o, rx_crc_ok_o, rx_len_err_o;
    logic [TYPE_WIDTH-1:0] rx_type_o;
    logic [CNT_WIDTH-1:0]  good_cnt_o, bad_cnt_o;

    // loopback control.
    logic                  loop_en;
    int                    corrupt_at;  // flipped word index or -1.
    logic [WORD_WIDTH-1:0] corrupt_mask;
    int                    trunc_at;  // word index with forced eof or -1.
    int                    word_cnt;  // words since the last sof.
    int                    cur_idx;

    // expected responses in frame order.
    logic [WORD_WIDTH-1:0] exp_crc_q[$];
    logic [WORD_WIDTH-1:0] exp_data_q[$];
    logic                  exp_ok_q[$];
    logic                  exp_len_err_q[$];
    logic [TYPE_WIDTH-1:0] exp_type_q[$];
    int                    exp_good, exp_bad, done_cnt;
    int                    err_cnt, check_cnt, test_cnt, test_err_base;
    string                 cur_test;

    always #4 clk_i = ~clk_i;

    crc_link_top u_dut (.*);

    always_comb begin
        cur_idx    = link_sof_o ? 0 : word_cnt;
        link_i     = '0;
        link_vld_i = 1'b0;
        link_sof_i = 1'b0;
        link_eof_i = 1'b0;
        if (loop_en && link_vld_o) begin
            link_i     = link_o ^ ((cur_idx == corrupt_at) ? corrupt_mask : '0);
            link_vld_i = !((trunc_at >= 0) && (cur_idx > trunc_at));  // rest of frame lost.
            link_sof_i = link_sof_o;
            link_eof_i = link_eof_o || (cur_idx == trunc_at);
        end
    end

    always @(posedge clk_i) begin
        if (link_vld_o) begin
            word_cnt <= cur_idx + 1;
        end
    end

    function automatic void check_value(input string what, input logic [31:0] exp,
                                        input logic [31:0] act);
        check_cnt++;
        assert (act === exp) else begin
            $display("error %s: %s expected %0h actual %0h", cur_test, what, exp, act);
            err_cnt++;
        end
    endfunction

    // bitwise MSB-first crc over the first n words.
    function automatic logic [15:0] ref_crc(input logic [WORD_WIDTH-1:0] words[$],
                                            input int n);
        logic [15:0] acc;
        logic        fb;
        acc = REF_INIT;
        for (int w = 0; w < n; w++) begin
            for (int b = WORD_WIDTH - 1; b >= 0; b--) begin
                fb  = acc[15] ^ words[w][b];
                acc = {acc[14:0], 1'b0} ^ (fb ? REF_POLY : 16'h0000);
            end
        end
        return acc;
    endfunction

    // monitor of the link crc word, rx payload and verdicts.
    always @(posedge clk_i) begin
        if (link_vld_o && link_eof_o) begin
            assert (exp_crc_q.size() > 0) else begin
                $display("%s: crc word sent with no frame started", cur_test);
                err_cnt++;
            end
            if (exp_crc_q.size() > 0) begin
                check_value("link crc word", 32'(exp_crc_q.pop_front()), 32'(link_o));
            end
        end
        if (rx_data_vld_o) begin
            assert (exp_data_q.size() > 0) else begin
                $display("%s: payload word %0h received with none expected", cur_test,
                         rx_data_o);
                err_cnt++;
            end
            if (exp_data_q.size() > 0) begin
                check_value("rx payload word", 32'(exp_data_q.pop_front()), 32'(rx_data_o));
            end
        end
        if (rx_done_o) begin
            done_cnt++;
            assert (exp_ok_q.size() > 0) else begin
                $display("%s: frame verdict with no frame sent", cur_test);
                err_cnt++;
            end
            if (exp_ok_q.size() > 0) begin
                check_value("rx_crc_ok_o", 32'(exp_ok_q.pop_front()), 32'(rx_crc_ok_o));
                check_value("rx_len_err_o", 32'(exp_len_err_q.pop_front()), 32'(rx_len_err_o));
                check_value("rx_type_o", 32'(exp_type_q.pop_front()), 32'(rx_type_o));
            end
        end
    end

    task automatic wait_tx_idle();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk_i);
            cycles++;
        end while (tx_busy_o && (cycles < FRAME_CYCLES));
        assert (!tx_busy_o) else begin
            $display("%s: framer still busy after %0d cycles", cur_test, cycles);
            err_cnt++;
        end
    endtask

    task automatic wait_verdicts(input int target);
        int cycles;
        cycles = 0;
        while ((done_cnt < target) && (cycles < FRAME_CYCLES)) begin
            @(posedge clk_i);
            cycles++;
        end
        assert (done_cnt >= target) else begin
            $display("%s: only %0d of %0d frame verdicts arrived", cur_test, done_cnt, target);
            err_cnt++;
        end
        repeat (2) @(posedge clk_i);  // counters follow one cycle later.
    endtask

    // sends one frame and books what the receive side must report.
    task automatic send_frame(input logic [TYPE_WIDTH-1:0] ftype, input int len,
                              input int max_gap, input int corrupt_idx,
                              input logic [WORD_WIDTH-1:0] mask, input int trunc_idx);
        logic [WORD_WIDTH-1:0] tx_words[$];
        logic [WORD_WIDTH-1:0] rx_words[$];
        logic [WORD_WIDTH-1:0] tx_crc;
        int                    last;  // word that closes the frame at the receiver.
        logic                  ok;
        logic                  len_err;
        int                    gap;
        tx_words.push_back({ftype, LEN_WIDTH'(len)});
        for (int i = 0; i < len; i++) begin
            tx_words.push_back(WORD_WIDTH'($urandom));
        end
        tx_crc = ref_crc(tx_words, len + 1);
        exp_crc_q.push_back(tx_crc);
        rx_words = tx_words;
        rx_words.push_back(tx_crc);
        if (corrupt_idx >= 0) begin
            rx_words[corrupt_idx] = rx_words[corrupt_idx] ^ mask;
        end
        last = (trunc_idx >= 0) ? trunc_idx : len + 1;
        for (int i = 1; i < last; i++) begin
            exp_data_q.push_back(rx_words[i]);
        end
        ok      = (ref_crc(rx_words, last) == rx_words[last]);  // early eof word too.
        len_err = (last != len + 1);
        exp_ok_q.push_back(ok);
        exp_len_err_q.push_back(len_err);
        exp_type_q.push_back(ftype);
        if (ok && !len_err) begin
            exp_good++;
        end else begin
            exp_bad++;
        end
        corrupt_at   <= corrupt_idx;
        corrupt_mask <= mask;
        trunc_at     <= trunc_idx;
        tx_start_i   <= 1'b1;
        tx_type_i    <= ftype;
        tx_len_i     <= LEN_WIDTH'(len);
        @(posedge clk_i);
        tx_start_i <= 1'b0;
        for (int i = 1; i <= len; i++) begin
            gap = (max_gap > 0) ? int'($urandom_range(max_gap, 0)) : 0;
            repeat (gap) begin
                tx_data_vld_i <= 1'b0;
                @(posedge clk_i);
            end
            tx_data_vld_i <= 1'b1;
            tx_data_i     <= tx_words[i];
            @(posedge clk_i);
        end
        tx_data_vld_i <= 1'b0;
        wait_tx_idle();
    endtask

    task automatic start_test(input string name);
        cur_test      = name;
        test_err_base = err_cnt;
    endtask

    task automatic report_test();
        check_value("good frame count", 32'(exp_good), 32'(good_cnt_o));
        check_value("bad frame count", 32'(exp_bad), 32'(bad_cnt_o));
        check_value("payload words never received", 0, 32'(exp_data_q.size()));
        test_cnt++;
        $display("%-16s %s, %0d errors", cur_test,
                 (err_cnt == test_err_base) ? "PASS" : "FAIL", err_cnt - test_err_base);
    endtask

    task automatic test_reset();
        start_test("reset");
        @(posedge clk_i);
        check_value("tx_busy_o", 0, 32'(tx_busy_o));
        check_value("link_vld_o", 0, 32'(link_vld_o));
        check_value("link_sof_o", 0, 32'(link_sof_o));
        check_value("link_eof_o", 0, 32'(link_eof_o));
        check_value("rx_data_vld_o", 0, 32'(rx_data_vld_o));
        check_value("rx_done_o", 0, 32'(rx_done_o));
        report_test();
    endtask

    task automatic test_single_frame();
        start_test("single_frame");
        send_frame(TYPE_WIDTH'($urandom), 8, MAX_GAP, -1, '0, -1);
        wait_verdicts(exp_good + exp_bad);
        check_value("good count after one frame", 1, 32'(good_cnt_o));
        report_test();
    endtask

    task automatic test_zero_length();
        start_test("zero_length");
        send_frame(TYPE_WIDTH'($urandom), 0, 0, -1, '0, -1);
        wait_verdicts(exp_good + exp_bad);
        report_test();
    endtask

    // flipped payload bit or forced early eof gives a bad frame.
    task automatic test_bad_frame(input string name, input int len, input int corrupt_idx,
                                  input int trunc_idx);
        logic [CNT_WIDTH-1:0]  good_before;
        logic [CNT_WIDTH-1:0]  bad_before;
        logic [WORD_WIDTH-1:0] mask;
        start_test(name);
        good_before = good_cnt_o;
        bad_before  = bad_cnt_o;
        mask        = WORD_WIDTH'(1) << $urandom_range(WORD_WIDTH - 1, 0);
        send_frame(TYPE_WIDTH'($urandom), len, 1, corrupt_idx, mask, trunc_idx);
        wait_verdicts(exp_good + exp_bad);
        check_value("bad count step", 32'(bad_before) + 1, 32'(bad_cnt_o));
        check_value("good count kept", 32'(good_before), 32'(good_cnt_o));
        report_test();
    endtask

    task automatic test_back_to_back();
        logic [CNT_WIDTH-1:0] good_before;
        start_test("back_to_back");
        good_before = good_cnt_o;
        for (int f = 0; f < 20; f++) begin
            send_frame(TYPE_WIDTH'($urandom), int'($urandom_range(MAX_RAND_LEN, 0)),
                       MAX_GAP, -1, '0, -1);
        end
        wait_verdicts(exp_good + exp_bad);
        check_value("good frames in burst", 32'(good_before) + 20, 32'(good_cnt_o));
        report_test();
    endtask

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk_i);
        $display("timeout: run still going after %0d clock cycles", TIMEOUT_CYCLES);
        $display("Checks failed");
        $finish;
    end

    initial begin
        void'($urandom(32'hcd53));
        rstn_i        = 1'b0;
        tx_start_i    = 1'b0;
        tx_type_i     = '0;
        tx_len_i      = '0;
        tx_data_vld_i = 1'b0;
        tx_data_i     = '0;
        loop_en       = 1'b0;
        corrupt_at    = -1;
        corrupt_mask  = '0;
        trunc_at      = -1;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rstn_i  <= 1'b1;
        loop_en <= 1'b1;
        test_reset();
        test_single_frame();
        test_zero_length();
        test_bad_frame("corrupt_payload", 8, int'($urandom_range(8, 1)), -1);
        test_bad_frame("truncated_frame", 6, -1, 3);
        test_back_to_back();
        $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== crc_link_top.f ====
src/crc_pkg.sv
src/link_pkg.sv
src/crc.sv
src/tx_framer.sv
src/rx_checker.sv
src/link_stats.sv
src/crc_link_top.sv
dv/tb_crc_link_top.sv

// ==== Makefile ====
# Verilator build and run of the CRC-16 framing link testbench.

VERILATOR ?= verilator
TOP       ?= tb_crc_link_top
FILELIST  ?= crc_link_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All checks passed

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
